/* common/bcfg_pkg.sv */
// Boot configuration shared types, address map and register offsets
package bcfg_pkg;

    // Register bus address and data
    typedef logic [15:0] addr_t;
    typedef logic [31:0] word_t;

    // Connector lines, line 0 at the MSB end as on the board schematics
    typedef logic [0:33] io1_t;
    typedef logic [0:39] io2_t;

    // Rotary switch value
    typedef logic [3:0] board_id_t;

    // Block codes in address bits 15:12
    localparam logic [3:0] ADDR_MAIN = 4'd0;
    localparam logic [3:0] ADDR_PROM = 4'd5;

    // Offsets in address bits 3:0 of the main block
    localparam logic [3:0] REG_STATUS  = 4'd0;
    localparam logic [3:0] REG_VERSION = 4'd1;

    // ASCII "BCFG"
    localparam word_t BCFG_VERSION = 32'h42434647;

    // Attached daughter board
    typedef enum logic [2:0] {
        NONE,
        QLA,
        DQLA,
        DRAC,
        UNKNOWN
    } board_t;

endpackage

/* common/reg_bus_if.sv */
// Register bus between the top-level decoder and the register blocks
`timescale 1ns/1ps

interface reg_bus_if
    import bcfg_pkg::*;
();

    addr_t raddr;
    addr_t waddr;
    word_t rdata;
    word_t wdata;
    // Already qualified for the target block
    logic  wen;

    // Decoder side
    modport master (
        output raddr, waddr, wdata, wen,
        input  rdata
    );

    // Register block side, rdata is combinational from raddr
    modport slave (
        input  raddr, waddr, wdata, wen,
        output rdata
    );

endinterface

/* rtl/board_detect.sv */
// Daughter board decoder from the power-up levels of the connector lines
`timescale 1ns/1ps

module board_detect
    import bcfg_pkg::*;
(
    input  logic       sysclk,
    input  logic       arst_n,
    input  io1_t       io1,
    input  io2_t       io2,
    output logic       is_none,
    output logic       is_qla,
    output logic       is_dqla,
    output logic       is_drac,
    output logic [4:0] term,
    output board_t     board
);

    logic   qla_zeros;
    logic   dqla_zeros;
    logic   dqla_ones;
    logic   drac_zeros;
    logic   drac_ones;
    logic   none_c;
    board_t board_c;

    // --------------------------------------------------
    // Detection terms
    // --------------------------------------------------

    // All lines pulled up, nothing attached
    assign none_c = (&io1) & (&io2);

    // QLA ties these low; DQLA, DRAC and NONE leave some high
    assign qla_zeros = ~(io1[0] | io1[31] | io1[32] |
                         io2[1] | io2[3] | io2[5] | io2[7] | io2[11] |
                         (|io2[31:38]));

    // DQLA
    assign dqla_zeros = ~io1[0];
    assign dqla_ones  = io1[12] & io1[31];

    // DRAC
    assign drac_zeros = ~(io1[9] | io1[12] | io1[19] | io1[21] | io1[23] | io1[32] |
                          io2[10] | io2[15] | io2[22] | io2[28] | io2[29] | io2[34]);
    assign drac_ones  = io2[1] & io2[3] & io2[31] & io2[32] & io2[36];

    // Board type, DRAC first so it agrees with is_drac
    always_comb begin
        if (drac_zeros && drac_ones) begin
            board_c = DRAC;
        end else if (dqla_zeros && dqla_ones) begin
            board_c = DQLA;
        end else if (qla_zeros) begin
            board_c = QLA;
        end else if (none_c) begin
            board_c = NONE;
        end else begin
            board_c = UNKNOWN;
        end
    end

    // One register stage from the lines to the flags
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            is_none <= 1'b0;
            is_qla  <= 1'b0;
            is_dqla <= 1'b0;
            is_drac <= 1'b0;
            term    <= 5'd0;
            board   <= UNKNOWN;
        end else begin
            is_none <= none_c;
            is_qla  <= qla_zeros;
            is_dqla <= dqla_zeros & dqla_ones;
            is_drac <= drac_zeros & drac_ones;
            // Same order as the status word
            term    <= {qla_zeros, dqla_zeros, dqla_ones, drac_zeros, drac_ones};
            board   <= board_c;
        end
    end

endmodule

/* prom/prom_spi.sv */
// SPI master running 32-bit command frames to the board EEPROM
`timescale 1ns/1ps

module prom_spi
    import bcfg_pkg::*;
#(
    parameter int PROM_CLK_DIV = 4
) (
    input  logic sysclk,
    input  logic arst_n,
    reg_bus_if.slave bus,
    output logic sclk,
    output logic mosi,
    output logic cs_n,
    input  logic miso
);

    localparam int DIV_W = (PROM_CLK_DIV > 1) ? $clog2(PROM_CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_END = DIV_W'(PROM_CLK_DIV - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SHIFT,
        S_DONE
    } spi_state_t;

    spi_state_t       state;
    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       bit_cnt;
    word_t            cmd_q;
    word_t            tx_q;
    logic [7:0]       rx_q;
    logic [7:0]       result;
    logic             busy;

    assign busy = (state != S_IDLE);
    assign mosi = tx_q[31];

    // Offset 0 is status and result, offset 1 reads back the command
    always_comb begin
        case (bus.raddr[3:0])
            4'd0:    bus.rdata = {busy, 23'd0, result};
            4'd1:    bus.rdata = cmd_q;
            default: bus.rdata = 32'd0;
        endcase
    end

    // --------------------------------------------------
    // Frame engine
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_IDLE;
            div_cnt <= '0;
            bit_cnt <= 5'd0;
            sclk    <= 1'b0;
            cs_n    <= 1'b1;
        end else begin
            case (state)
                S_IDLE: begin
                    // Commands written while busy fall through to nothing
                    if (bus.wen && bus.waddr[3:0] == 4'd0) begin
                        state   <= S_SHIFT;
                        cs_n    <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= 5'd0;
                    end
                end
                S_SHIFT: begin
                    if (div_cnt == DIV_END) begin
                        div_cnt <= '0;
                        sclk    <= ~sclk;
                        // Falling edge closes the bit
                        if (sclk) begin
                            bit_cnt <= bit_cnt + 5'd1;
                            if (bit_cnt == 5'd31) begin
                                state <= S_DONE;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                S_DONE: begin
                    cs_n  <= 1'b1;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge sysclk) begin
        if (state == S_IDLE && bus.wen && bus.waddr[3:0] == 4'd0) begin
            cmd_q <= bus.wdata;
            tx_q  <= bus.wdata;
        end else if (state == S_SHIFT && div_cnt == DIV_END) begin
            if (!sclk) begin
                // Sample on rising sclk
                rx_q <= {rx_q[6:0], miso};
            end else begin
                tx_q <= {tx_q[30:0], 1'b0};
            end
        end
        // Last byte of the reply
        if (state == S_DONE) begin
            result <= rx_q;
        end
    end

endmodule

/* rtl/sample_buffer.sv */
// Free-running timestamp and four-word snapshot for block reads
`timescale 1ns/1ps

module sample_buffer
    import bcfg_pkg::*;
(
    input  logic        sysclk,
    input  logic        arst_n,
    input  logic        sample_start,
    output logic        sample_busy,
    input  logic [5:0]  sample_raddr,
    output word_t       sample_rdata,
    output word_t       timestamp,
    input  logic [21:0] status_hi,
    input  io1_t        io1,
    input  io2_t        io2
);

    word_t snap [4];
    logic  capture;

    // New start only when the previous one has been released
    assign capture = sample_start & ~sample_busy;

    assign sample_rdata = snap[sample_raddr[1:0]];

    // Timestamp restarts at each capture
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            timestamp   <= 32'd0;
            sample_busy <= 1'b0;
        end else begin
            timestamp   <= capture ? 32'd0 : timestamp + 32'd1;
            // Held while start is high
            sample_busy <= sample_start;
        end
    end

    // --------------------------------------------------
    // Snapshot words
    // --------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (capture) begin
            // Old timestamp, before the clear
            snap[0] <= timestamp;
            snap[1] <= {status_hi, io1[0:9]};
            snap[2] <= {io1[10:33], io2[0:7]};
            snap[3] <= io2[8:39];
        end
    end

endmodule

/* led/led_chain.sv */
// Front-panel LED walker with WS2811 serial encoding
`timescale 1ns/1ps

module led_chain #(
    parameter int NUM_LEDS     = 7,
    parameter int LED_T0H      = 15,
    parameter int LED_T1H      = 30,
    parameter int LED_TBIT     = 61,
    parameter int LED_RESET    = 2500,
    parameter int BLINK_CYCLES = 12_288_000
) (
    input  logic sysclk,
    input  logic arst_n,
    output logic led_do
);

    localparam int IDX_W   = $clog2(NUM_LEDS + 1);
    localparam int CNT_W   = $clog2(LED_RESET + LED_TBIT + 1);
    localparam int BLINK_W = $clog2(BLINK_CYCLES + 1);

    localparam logic [IDX_W-1:0]   LAST_LED  = IDX_W'(NUM_LEDS - 1);
    localparam logic [CNT_W-1:0]   T0H_END   = CNT_W'(LED_T0H - 1);
    localparam logic [CNT_W-1:0]   T1H_END   = CNT_W'(LED_T1H - 1);
    localparam logic [CNT_W-1:0]   TBIT_END  = CNT_W'(LED_TBIT - 1);
    localparam logic [CNT_W-1:0]   RESET_END = CNT_W'(LED_RESET - 1);
    localparam logic [BLINK_W-1:0] BLINK_END = BLINK_W'(BLINK_CYCLES - 1);

    // GRB word of the lit LED, green 50
    localparam logic [23:0] LIT_WORD = {8'd50, 8'd0, 8'd0};

    typedef enum logic [1:0] {
        S_RESET,
        S_HIGH,
        S_LOW
    } led_state_t;

    led_state_t         state;
    logic [BLINK_W-1:0] blink_cnt;
    logic [IDX_W-1:0]   on_led;
    logic [IDX_W-1:0]   lit_q;
    logic [IDX_W-1:0]   led_idx;
    logic [4:0]         bit_idx;
    logic [CNT_W-1:0]   cnt;
    logic               cur_bit;

    // --------------------------------------------------
    // Blink sequencer, LED 0 stays dark
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            blink_cnt <= '0;
            on_led    <= IDX_W'(1);
        end else if (blink_cnt == BLINK_END) begin
            blink_cnt <= '0;
            on_led    <= (on_led == LAST_LED) ? IDX_W'(1) : on_led + 1'b1;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    // Current bit, MSB first
    assign cur_bit = (led_idx == lit_q) ? LIT_WORD[bit_idx] : 1'b0;

    assign led_do = (state == S_HIGH);

    // --------------------------------------------------
    // Serializer
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_RESET;
            cnt     <= '0;
            led_idx <= '0;
            bit_idx <= 5'd23;
            lit_q   <= IDX_W'(1);
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                S_RESET: begin
                    if (cnt == RESET_END) begin
                        // Frame start, freeze the lit index
                        state   <= S_HIGH;
                        cnt     <= '0;
                        led_idx <= '0;
                        bit_idx <= 5'd23;
                        lit_q   <= on_led;
                    end
                end
                S_HIGH: begin
                    if (cnt == (cur_bit ? T1H_END : T0H_END)) begin
                        state <= S_LOW;
                    end
                end
                S_LOW: begin
                    if (cnt == TBIT_END) begin
                        cnt   <= '0;
                        state <= S_HIGH;
                        if (bit_idx != 5'd0) begin
                            bit_idx <= bit_idx - 5'd1;
                        end else if (led_idx == LAST_LED) begin
                            state <= S_RESET;
                        end else begin
                            led_idx <= led_idx + 1'b1;
                            bit_idx <= 5'd23;
                        end
                    end
                end
                default: state <= S_RESET;
            endcase
        end
    end

endmodule

/* rtl/boot_config.sv */
// Boot configuration check top level with register map and board pins
`timescale 1ns/1ps

module boot_config
    import bcfg_pkg::*;
#(
    parameter int PROM_CLK_DIV = 4,
    parameter int NUM_LEDS     = 7,
    parameter int LED_T0H      = 15,
    parameter int LED_T1H      = 30,
    parameter int LED_TBIT     = 61,
    parameter int LED_RESET    = 2500,
    parameter int BLINK_CYCLES = 12_288_000
) (
    input  logic        sysclk,
    input  logic        arst_n,
    input  board_id_t   board_id,
    input  logic        is_v30,
    input  io1_t        io1,
    input  io2_t        io2,
    input  addr_t       reg_raddr,
    input  addr_t       reg_waddr,
    input  word_t       reg_wdata,
    input  logic        reg_wen,
    output word_t       reg_rdata,
    output logic [63:0] emio,
    input  logic        sample_start,
    output logic        sample_busy,
    input  logic [5:0]  sample_raddr,
    output word_t       sample_rdata,
    output word_t       timestamp,
    output logic        prom_sclk,
    output logic        prom_mosi,
    output logic        prom_cs_n,
    input  logic        prom_miso,
    output logic        led_do
);

    logic       is_none, is_qla, is_dqla, is_drac;
    logic [4:0] term;
    board_t     board;
    word_t      status;
    logic       spi_sclk, spi_mosi, led_raw;

    reg_bus_if bus_if ();

    board_detect u_detect (
        .sysclk (sysclk), .arst_n (arst_n), .io1 (io1), .io2 (io2),
        .is_none (is_none), .is_qla (is_qla), .is_dqla (is_dqla), .is_drac (is_drac),
        .term (term), .board (board)
    );

    // --------------------------------------------------
    // Register bus to the EEPROM controller
    // --------------------------------------------------
    assign bus_if.raddr = reg_raddr;
    assign bus_if.waddr = reg_waddr;
    assign bus_if.wdata = reg_wdata;
    // PROM block, low register page only
    assign bus_if.wen   = reg_wen && (reg_waddr[15:12] == ADDR_PROM) && (reg_waddr[7:4] == 4'd0);

    prom_spi #(.PROM_CLK_DIV(PROM_CLK_DIV)) u_prom (
        .sysclk (sysclk), .arst_n (arst_n), .bus (bus_if.slave),
        .sclk (spi_sclk), .mosi (spi_mosi), .cs_n (prom_cs_n), .miso (prom_miso)
    );

    // Clock and data only driven inside a frame
    assign prom_sclk = ~prom_cs_n & spi_sclk;
    assign prom_mosi = ~prom_cs_n & spi_mosi;

    // Flags, raw terms, low bits zero
    assign status = {4'd0, board_id, is_none, is_qla, is_dqla, is_drac, is_v30, term, 14'd0};
    assign emio = {BCFG_VERSION, status};

    // Read mux on the block code
    always_comb begin
        case (reg_raddr[15:12])
            ADDR_PROM: reg_rdata = bus_if.rdata;
            ADDR_MAIN: begin
                if (reg_raddr[3:0] == REG_STATUS) begin
                    reg_rdata = status;
                end else if (reg_raddr[3:0] == REG_VERSION) begin
                    reg_rdata = BCFG_VERSION;
                end else begin
                    reg_rdata = 32'd0;
                end
            end
            default:   reg_rdata = 32'd0;
        endcase
    end

    sample_buffer u_sample (
        .sysclk (sysclk), .arst_n (arst_n),
        .sample_start (sample_start), .sample_busy (sample_busy),
        .sample_raddr (sample_raddr), .sample_rdata (sample_rdata),
        .timestamp (timestamp), .status_hi (status[31:10]), .io1 (io1), .io2 (io2)
    );

    led_chain #(
        .NUM_LEDS (NUM_LEDS), .LED_T0H (LED_T0H), .LED_T1H (LED_T1H),
        .LED_TBIT (LED_TBIT), .LED_RESET (LED_RESET), .BLINK_CYCLES (BLINK_CYCLES)
    ) u_led (
        .sysclk (sysclk), .arst_n (arst_n), .led_do (led_raw)
    );

    // LED pin belongs to the DRAC only
    assign led_do = (board == DRAC) & led_raw;

endmodule

/* tb/prom_model.sv */
// Behavioral 25AA128 EEPROM answering read frames on SPI mode 0
`timescale 1ns/1ps

module prom_model (
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic miso
);

    logic [31:0] shift_in;
    logic [5:0]  bit_cnt;
    logic [7:0]  opcode;
    logic [7:0]  dout;

    initial begin
        shift_in = 32'd0;
        bit_cnt  = 6'd0;
        opcode   = 8'd0;
        dout     = 8'd0;
    end

    // Command and address bits taken on rising sclk
    always @(posedge sclk or posedge cs_n) begin
        if (cs_n) begin
            bit_cnt <= 6'd0;
        end else begin
            shift_in <= {shift_in[30:0], mosi};
            bit_cnt  <= bit_cnt + 6'd1;
            // Last address bit arrives now
            if (bit_cnt == 6'd23) begin
                opcode <= shift_in[22:15];
                dout   <= {shift_in[6:0], mosi} ^ 8'hA5;
            end
        end
    end

    // Data byte MSB first after the address phase
    always_comb begin
        if (!cs_n && opcode == 8'h03 && bit_cnt >= 6'd24 && bit_cnt <= 6'd31) begin
            miso = dout[3'(6'd31 - bit_cnt)];
        end else begin
            miso = 1'b0;
        end
    end

endmodule

/* tb/boot_config_tb.sv */
// Testbench for the boot configuration top level with reference model checks
`timescale 1ns/1ps

module boot_config_tb
    import bcfg_pkg::*;
;

    localparam int DIV        = 2;
    localparam int NLEDS      = 3;
    localparam int T0H        = 2;
    localparam int T1H        = 4;
    localparam int TBIT       = 8;
    localparam int TRESET     = 20;
    localparam int BLINK      = 500;
    localparam int N_DETECT   = 20;
    localparam int N_PROM     = 8;
    localparam int N_SAMPLE   = 8;
    localparam int PROM_FRAME = 32 * 2 * DIV + 8;
    localparam int NUM_TESTS  = N_DETECT + N_PROM + N_SAMPLE + 3;
    localparam int TIMEOUT    = NUM_TESTS * PROM_FRAME * 2;

    // ASCII version word
    localparam word_t VERSION_WORD = "BCFG";

    logic        sysclk, arst_n, is_v30, reg_wen, sample_start, led_do;
    board_id_t   board_id;
    io1_t        io1;
    io2_t        io2;
    addr_t       reg_raddr, reg_waddr;
    word_t       reg_wdata, reg_rdata, sample_rdata, timestamp;
    logic [63:0] emio;
    logic [5:0]  sample_raddr;
    logic        sample_busy, prom_sclk, prom_mosi, prom_cs_n, prom_miso;
    word_t       ts_model;
    logic        start_q;

    int seed = 68140;
    int checks = 0;
    int errors = 0;
    int cycle_cnt = 0;

    boot_config #(
        .PROM_CLK_DIV (DIV), .NUM_LEDS (NLEDS), .LED_T0H (T0H), .LED_T1H (T1H),
        .LED_TBIT (TBIT), .LED_RESET (TRESET), .BLINK_CYCLES (BLINK)
    ) uut (
        .sysclk (sysclk), .arst_n (arst_n), .board_id (board_id), .is_v30 (is_v30),
        .io1 (io1), .io2 (io2), .reg_raddr (reg_raddr), .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata), .reg_wen (reg_wen), .reg_rdata (reg_rdata), .emio (emio),
        .sample_start (sample_start), .sample_busy (sample_busy),
        .sample_raddr (sample_raddr), .sample_rdata (sample_rdata), .timestamp (timestamp),
        .prom_sclk (prom_sclk), .prom_mosi (prom_mosi), .prom_cs_n (prom_cs_n),
        .prom_miso (prom_miso), .led_do (led_do)
    );

    prom_model u_prom_model (
        .sclk (prom_sclk), .cs_n (prom_cs_n), .mosi (prom_mosi), .miso (prom_miso)
    );

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    // Watchdog
    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout: run exceeded %0d cycles", TIMEOUT);
            $display("Regression failed");
            $finish;
        end
    end

    // Timestamp model, cleared by a start that finds the buffer idle
    always @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            ts_model <= 32'd0;
            start_q  <= 1'b0;
        end else begin
            ts_model <= (sample_start && !start_q) ? 32'd0 : ts_model + 32'd1;
            start_q  <= sample_start;
        end
    end

    // --------------------------------------------------
    // Helpers and reference model
    // --------------------------------------------------
    task automatic log_error(input string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic rand_word(output word_t w);
        w = $random(seed);
    endtask

    // Status word built from the detection rules
    function automatic word_t model_status(input io1_t a, input io2_t b,
                                           input board_id_t id, input logic v30);
        logic none, qz, dz, d1, rz, r1;
        none = (&a) && (&b);
        qz = !a[0] && !a[31] && !a[32] && !b[1] && !b[3] && !b[5] && !b[7] && !b[11]
             && (b[31:38] == 8'd0);
        dz = !a[0];
        d1 = a[12] && a[31];
        rz = !a[9] && !a[12] && !a[19] && !a[21] && !a[23] && !a[32]
             && !b[10] && !b[15] && !b[22] && !b[28] && !b[29] && !b[34];
        r1 = b[1] && b[3] && b[31] && b[32] && b[36];
        return {4'd0, id, none, qz, dz && d1, rz && r1, v30, qz, dz, d1, rz, r1, 14'd0};
    endfunction

    // Kind 0 random, 1 NONE, 2 QLA, 3 DQLA, 4 DRAC
    task automatic make_pattern(input int kind, output io1_t a, output io2_t b);
        word_t r1, r2, r3, r4;
        rand_word(r1);
        rand_word(r2);
        rand_word(r3);
        rand_word(r4);
        a = {r1, r2[1:0]};
        b = {r3, r4[7:0]};
        case (kind)
            1: begin
                a = '1;
                b = '1;
            end
            2: begin
                {a[0], a[31], a[32]} = 3'b000;
                {b[1], b[3], b[5], b[7], b[11]} = 5'b00000;
                b[31:38] = 8'd0;
            end
            3: begin
                {a[0], a[12], a[31]} = 3'b011;
            end
            4: begin
                {a[9], a[12], a[19], a[21], a[23], a[32]} = 6'd0;
                {b[10], b[15], b[22], b[28], b[29], b[34]} = 6'd0;
                {b[1], b[3], b[31], b[32], b[36]} = 5'b11111;
            end
            default: ;
        endcase
    endtask

    // Apply lines, id and version flag, then let the flags settle
    task automatic apply_pattern(input int kind);
        io1_t  a;
        io2_t  b;
        word_t r;
        make_pattern(kind, a, b);
        rand_word(r);
        @(posedge sysclk);
        io1      <= a;
        io2      <= b;
        board_id <= r[3:0];
        is_v30   <= r[4];
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
    endtask

    task automatic reg_read(input addr_t addr, output word_t data);
        @(posedge sysclk);
        reg_raddr <= addr;
        @(negedge sysclk);
        data = reg_rdata;
    endtask

    task automatic reg_write(input addr_t addr, input word_t data);
        @(posedge sysclk);
        reg_waddr <= addr;
        reg_wdata <= data;
        reg_wen   <= 1'b1;
        @(posedge sysclk);
        reg_wen   <= 1'b0;
        @(negedge sysclk);
    endtask

    task automatic test_done(input string name, input int c0, input int e0);
        $display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic sweep_detection();
        word_t exp, got;
        int c0, e0;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_DETECT; i++) begin
            apply_pattern(i % 5);
            exp = model_status(io1, io2, board_id, is_v30);
            reg_read({ADDR_MAIN, 8'd0, REG_STATUS}, got);
            checks += 2;
            if (got !== exp) log_error($sformatf("status got %h exp %h", got, exp));
            if (emio !== {VERSION_WORD, exp}) log_error($sformatf("emio got %h", emio));
        end
        test_done("detection", c0, e0);
    endtask

    task automatic probe_register_map();
        word_t got;
        int c0, e0;
        c0 = checks;
        e0 = errors;
        reg_read({ADDR_MAIN, 8'd0, REG_VERSION}, got);
        checks++;
        if (got !== VERSION_WORD) log_error($sformatf("version got %h", got));
        reg_read(16'h3000, got);
        checks++;
        if (got !== 32'd0) log_error($sformatf("unmapped block got %h", got));
        reg_read(16'h0002, got);
        checks++;
        if (got !== 32'd0) log_error($sformatf("unmapped offset got %h", got));
        test_done("register map", c0, e0);
    endtask

    task automatic read_prom();
        word_t r, r2, cmd, got;
        logic [7:0] exp;
        int c0, e0, wait_cnt;
        c0 = checks;
        e0 = errors;
        @(posedge sysclk);
        reg_raddr <= 16'h5000;
        // Upper register page of the PROM block takes no command
        reg_write(16'h5010, {8'h03, 24'h0});
        checks++;
        if (reg_rdata[31] !== 1'b0) log_error("busy set by a write outside the PROM page");
        for (int i = 0; i < N_PROM; i++) begin
            rand_word(r);
            rand_word(r2);
            exp = r[7:0] ^ 8'hA5;
            cmd = {8'h03, r[15:0], 8'h00};
            reg_write(16'h5000, cmd);
            checks++;
            if (reg_rdata[31] !== 1'b1) log_error("busy not set after command");
            // Ignored while the frame runs
            repeat (3) @(posedge sysclk);
            reg_write(16'h5000, {8'h03, r2[15:0] ^ 16'h00FF, 8'h00});
            wait_cnt = 0;
            while (reg_rdata[31] === 1'b1 && wait_cnt < 2 * PROM_FRAME) begin
                @(negedge sysclk);
                wait_cnt++;
            end
            checks++;
            if (reg_rdata[31] !== 1'b0) begin
                errors++;
                $display("PROM busy never cleared at %0t", $time);
            end
            got = reg_rdata;
            checks++;
            if (got[7:0] !== exp) log_error($sformatf("PROM result got %h exp %h", got[7:0], exp));
            // Command register keeps the first command
            reg_read(16'h5001, got);
            checks++;
            if (got !== cmd) log_error($sformatf("PROM command got %h exp %h", got, cmd));
            @(posedge sysclk);
            reg_raddr <= 16'h5000;
        end
        test_done("prom read", c0, e0);
    endtask

    task automatic pulse_samples();
        word_t r, ts_exp, st, got;
        word_t exp [4];
        int c0, e0, hold;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_SAMPLE; i++) begin
            apply_pattern(i % 5);
            rand_word(r);
            repeat (r[2:0]) @(posedge sysclk);
            @(posedge sysclk);
            sample_start <= 1'b1;
            @(negedge sysclk);
            // Values seen by the capture edge
            ts_exp = ts_model;
            st = model_status(io1, io2, board_id, is_v30);
            exp[0] = ts_exp;
            exp[1] = {st[31:10], io1[0:9]};
            exp[2] = {io1[10:33], io2[0:7]};
            exp[3] = io2[8:39];
            @(negedge sysclk);
            checks += 2;
            if (timestamp !== 32'd0) log_error($sformatf("timestamp got %0d after start", timestamp));
            if (sample_busy !== 1'b1) log_error("sample busy not set");
            hold = 1 + int'(r[5:4]);
            for (int k = 0; k < hold; k++) begin
                @(negedge sysclk);
                checks += 2;
                if (timestamp !== 32'(k + 1)) log_error($sformatf("timestamp got %0d", timestamp));
                if (sample_busy !== 1'b1) log_error("sample busy dropped while start high");
            end
            @(posedge sysclk);
            sample_start <= 1'b0;
            @(negedge sysclk);
            checks++;
            if (sample_busy !== 1'b1) log_error("sample busy dropped early");
            @(negedge sysclk);
            checks++;
            if (sample_busy !== 1'b0) log_error("sample busy stuck after start fell");
            for (int k = 0; k < 4; k++) begin
                @(posedge sysclk);
                sample_raddr <= 6'(k);
                @(negedge sysclk);
                got = sample_rdata;
                checks++;
                if (got !== exp[k]) begin
                    log_error($sformatf("sample word %0d got %h exp %h", k, got, exp[k]));
                end
            end
        end
        test_done("sampling", c0, e0);
    endtask

    task automatic decode_leds();
        logic [23:0] frame [NLEDS];
        int c0, e0, low_run, width, lit_cnt;
        c0 = checks;
        e0 = errors;
        apply_pattern(4);
        // Frame gap is the only long low stretch
        low_run = 0;
        while (low_run < 12) begin
            @(negedge sysclk);
            low_run = led_do ? 0 : low_run + 1;
        end
        for (int n = 0; n < NLEDS; n++) begin
            for (int b = 23; b >= 0; b--) begin
                while (!led_do) @(negedge sysclk);
                width = 0;
                while (led_do) begin
                    width++;
                    @(negedge sysclk);
                end
                checks++;
                if (width != T0H && width != T1H) begin
                    log_error($sformatf("LED pulse width of %0d cycles", width));
                end
                frame[n][b] = (width > (T0H + T1H) / 2);
            end
        end
        lit_cnt = 0;
        for (int n = 0; n < NLEDS; n++) begin
            checks++;
            if (frame[n] !== 24'h320000 && frame[n] !== 24'h0) begin
                log_error($sformatf("LED %0d word %h", n, frame[n]));
            end
            if (frame[n] === 24'h320000) lit_cnt++;
        end
        checks += 2;
        if (lit_cnt != 1) log_error($sformatf("%0d LEDs lit", lit_cnt));
        if (frame[0] !== 24'h0) log_error("LED 0 lit");
        apply_pattern(1);
        for (int k = 0; k < 2 * (NLEDS * 24 * TBIT + TRESET); k++) begin
            @(negedge sysclk);
            checks++;
            if (led_do !== 1'b0) log_error("led_do active without DRAC");
        end
        test_done("leds", c0, e0);
    endtask

    initial begin
        arst_n       = 1'b0;
        board_id     = '0;
        is_v30       = 1'b0;
        io1          = '1;
        io2          = '1;
        reg_raddr    = '0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        sample_start = 1'b0;
        sample_raddr = '0;
        repeat (4) @(negedge sysclk);
        checks++;
        if (prom_cs_n !== 1'b1 || prom_sclk !== 1'b0 || sample_busy !== 1'b0
            || led_do !== 1'b0 || emio[23:14] !== 10'd0) begin
            log_error("outputs not at their reset values during reset");
        end
        repeat (4) @(posedge sysclk);
        arst_n <= 1'b1;
        sweep_detection();
        probe_register_map();
        read_prom();
        pulse_samples();
        decode_leds();
        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* tb.f */
common/bcfg_pkg.sv
common/reg_bus_if.sv
rtl/board_detect.sv
prom/prom_spi.sv
rtl/sample_buffer.sv
led/led_chain.sv
rtl/boot_config.sv
tb/prom_model.sv
tb/boot_config_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= boot_config_tb
RTL_TOP   ?= boot_config
FILELIST  ?= tb.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Regression passed$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) \
		common/bcfg_pkg.sv common/reg_bus_if.sv rtl/board_detect.sv \
		prom/prom_spi.sv rtl/sample_buffer.sv led/led_chain.sv rtl/boot_config.sv

clean:
	rm -rf obj_dir
